//--- rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    op_imm    = 7'b001_0011,
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_system = 7'b111_0011
  } opcode_t;

  localparam logic [2:0] f3_addi   = 3'd0;
  // access sizes, shared by loads and stores
  localparam logic [2:0] f3_byte   = 3'd0;
  localparam logic [2:0] f3_half   = 3'd1;
  localparam logic [2:0] f3_word   = 3'd2;
  localparam logic [2:0] f3_byte_u = 3'd4;
  localparam logic [2:0] f3_half_u = 3'd5;

  localparam logic [xlen-1:0] ebreak_word = 32'h0010_0073;

  typedef struct packed {
    logic [11:0]           imm;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    opcode_t               opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    opcode_t               opcode;
  } inst_s_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [reg_addr_w-1:0] rd;
    opcode_t               opcode;
  } inst_u_t;

  // jal immediate is scrambled in the word
  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [reg_addr_w-1:0] rd;
    opcode_t               opcode;
  } inst_j_t;

  typedef union packed {
    inst_i_t i;
    inst_s_t s;
    inst_u_t u;
    inst_j_t j;
  } inst_u;

endpackage

//--- core_pkg.sv
package core_pkg;

  localparam int unsigned word_w = 32;

  localparam logic [word_w-1:0] reset_vector = 32'h8000_0000;

  // write-back source select
  localparam logic [1:0] wb_sum  = 2'd0;
  localparam logic [1:0] wb_link = 2'd1;
  localparam logic [1:0] wb_load = 2'd2;

  typedef struct packed {
    logic [word_w-1:0] addr;
    logic [word_w-1:0] wdata;
    logic [3:0]        wmask; // one bit per byte lane
    logic              read;
    logic              write;
  } dmem_req_t;

  typedef struct packed {
    logic              op_a_pc;   // adder takes pc instead of rs1
    logic [word_w-1:0] imm;
    logic              reg_write;
    logic [1:0]        wb_sel;
    logic              jump;
    logic              mem_read;
    logic              mem_write;
    logic [2:0]        funct3;
    logic              is_ebreak;
    logic              illegal;
  } ctrl_t;

endpackage

//--- regfile.sv
`timescale 1ns/100ps

module regfile
  import rv_isa_pkg::*;
(
  input  logic                  clk,
  input  logic [reg_addr_w-1:0] rs1_addr,
  input  logic [reg_addr_w-1:0] rs2_addr,
  input  logic [reg_addr_w-1:0] rd_addr,
  input  logic [xlen-1:0]       rd_data,
  input  logic                  wen,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (wen && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data; // entry 0 is never written
    end
  end

  // async reads, x0 hardwired
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // a write aimed at x0 leaves it reading zero afterwards
  assert property (@(posedge clk)
    (wen && (rd_addr == '0)) |=>
      ((rs1_addr != '0) || (rs1_data == '0)) && ((rs2_addr != '0) || (rs2_data == '0)))
    else $error("x0 read back nonzero after a write to it");

endmodule

//--- decoder.sv
`timescale 1ns/100ps

module decoder
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  inst_u                 inst,
  output ctrl_t                 ctrl,
  output logic [reg_addr_w-1:0] rs1_addr,
  output logic [reg_addr_w-1:0] rs2_addr,
  output logic [reg_addr_w-1:0] rd_addr
);

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_u = {inst.u.imm, 12'h000}; // already shifted for lui
  assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};

  // lui reads x0 so the adder passes the immediate through
  assign rs1_addr = (inst.i.opcode == op_lui) ? '0 : inst.i.rs1;
  assign rs2_addr = inst.s.rs2;
  assign rd_addr  = inst.i.rd;

  always_comb begin
    ctrl           = '0;
    ctrl.imm       = imm_i;
    ctrl.wb_sel    = wb_sum;
    ctrl.funct3    = inst.i.funct3;

    case (inst.i.opcode)
      op_imm: begin
        if (inst.i.funct3 == f3_addi) ctrl.reg_write = 1'b1;
        else ctrl.illegal = 1'b1; // other op-imm not supported
      end
      op_lui: begin
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      op_auipc: begin
        ctrl.op_a_pc   = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      op_jal: begin
        ctrl.op_a_pc   = 1'b1;
        ctrl.imm       = imm_j;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = wb_link;
        ctrl.jump      = 1'b1;
      end
      op_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = wb_link;
        ctrl.jump      = 1'b1;
      end
      op_load: begin
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = wb_load;
        ctrl.illegal   = !(inst.i.funct3 inside {f3_byte, f3_half, f3_word,
                                                 f3_byte_u, f3_half_u});
      end
      op_store: begin
        ctrl.imm       = imm_s;
        ctrl.mem_write = 1'b1;
        ctrl.illegal   = !(inst.s.funct3 inside {f3_byte, f3_half, f3_word});
      end
      op_system: begin
        if (inst == ebreak_word) ctrl.is_ebreak = 1'b1;
        else ctrl.illegal = 1'b1;
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // nothing illegal touches state
    if (ctrl.illegal) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
    end
  end

  always_comb begin
    assert final (!(ctrl.mem_read && ctrl.mem_write))
      else $error("decoder raised load and store together");
  end

endmodule

//--- lsu.sv
`timescale 1ns/100ps

module lsu
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  ctrl_t             ctrl,
  input  logic [xlen-1:0]   addr,
  input  logic [xlen-1:0]   store_data,
  input  logic [word_w-1:0] rdata,
  input  logic              block,     // reset or halt
  output dmem_req_t         dmem_req,
  output logic [xlen-1:0]   load_data
);

  logic [7:0]        load_byte;
  logic [15:0]       load_half;
  logic [3:0]        store_mask;
  logic [word_w-1:0] store_word;
  logic              read_en;
  logic              write_en;
  logic              misaligned;

  // lane picked by the low address bits
  assign load_byte = rdata[{addr[1:0], 3'b000} +: 8];
  assign load_half = addr[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (ctrl.funct3)
      f3_byte:   load_data = {{24{load_byte[7]}}, load_byte};
      f3_half:   load_data = {{16{load_half[15]}}, load_half};
      f3_word:   load_data = rdata;
      f3_byte_u: load_data = {24'h00_0000, load_byte};
      f3_half_u: load_data = {16'h0000, load_half};
      default:   load_data = '0;
    endcase
  end

  // stores replicate the value, the mask says which lanes land
  always_comb begin
    case (ctrl.funct3)
      f3_byte: begin
        store_word = {4{store_data[7:0]}};
        store_mask = 4'b0001 << addr[1:0];
      end
      f3_half: begin
        store_word = {2{store_data[15:0]}};
        store_mask = addr[1] ? 4'b1100 : 4'b0011;
      end
      f3_word: begin
        store_word = store_data;
        store_mask = 4'b1111;
      end
      default: begin
        store_word = '0;
        store_mask = 4'b0000;
      end
    endcase
  end

  assign read_en  = ctrl.mem_read & ~block;
  assign write_en = ctrl.mem_write & ~block;

  always_comb begin
    dmem_req.addr  = addr;
    dmem_req.wdata = store_word;
    dmem_req.wmask = write_en ? store_mask : 4'b0000;
    dmem_req.read  = read_en;
    dmem_req.write = write_en;
  end

  always_comb begin
    case (ctrl.funct3)
      f3_half, f3_half_u: misaligned = addr[0];
      f3_word:            misaligned = |addr[1:0];
      default:            misaligned = 1'b0;
    endcase
  end

  always_comb begin
    assert final (!((read_en || write_en) && misaligned))
      else $error("misaligned data access at %h", addr);
  end

endmodule

//--- core_top.sv
`timescale 1ns/100ps

module core_top
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [xlen-1:0]   inst,
  output logic [xlen-1:0]   pc,
  output dmem_req_t         dmem_req,
  input  logic [word_w-1:0] dmem_rdata,
  output logic              halted
);

  ctrl_t                 ctrl;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [reg_addr_w-1:0] rd_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       operand;
  logic [xlen-1:0]       sum;
  logic [xlen-1:0]       pc_plus4;
  logic [xlen-1:0]       next_pc;
  logic [xlen-1:0]       load_data;
  logic [xlen-1:0]       wb_data;
  logic                  block;
  logic                  reg_wen;

  decoder decoder0 (
    .inst     (inst),
    .ctrl     (ctrl),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr)
  );

  regfile regfile0 (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_data  (wb_data),
    .wen      (reg_wen),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  lsu lsu0 (
    .ctrl       (ctrl),
    .addr       (sum),
    .store_data (rs2_data),
    .rdata      (dmem_rdata),
    .block      (block),
    .dmem_req   (dmem_req),
    .load_data  (load_data)
  );

  assign block   = reset | halted;
  assign reg_wen = ctrl.reg_write & ~block;

  // one adder serves addresses, jump targets and alu results
  assign operand  = ctrl.op_a_pc ? pc : rs1_data;
  assign sum      = operand + ctrl.imm;
  assign pc_plus4 = pc + 32'd4;
  assign next_pc  = ctrl.jump ? {sum[xlen-1:1], 1'b0} : pc_plus4; // jalr drops bit 0

  always_comb begin
    case (ctrl.wb_sel)
      wb_link: wb_data = pc_plus4;
      wb_load: wb_data = load_data;
      default: wb_data = sum;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= reset_vector;
      halted <= 1'b0;
    end else if (!halted) begin
      if (ctrl.is_ebreak) halted <= 1'b1; // pc stays on the ebreak
      else pc <= next_pc;
    end
  end

  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc lost word alignment: %h", pc);

  assert property (@(posedge clk) disable iff (reset) !halted |-> !ctrl.illegal)
    else $error("illegal instruction %h at pc %h", inst, pc);

endmodule

//--- tb_program.svh
// result words go to the upper half of the RAM, one per save
int unsigned out_off;

function automatic logic [31:0] small_imm();
  logic [31:0] r;
  r = next_random();
  return {{20{r[11]}}, r[11:0]};
endfunction

function automatic logic [31:0] upper_imm();
  logic [31:0] r;
  r = next_random();
  return {r[31:12], 12'h000};
endfunction

// imm is the value the instruction means, encoded into the matching view
task automatic add_instr(opcode_t op, logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                         logic [4:0] rs2, logic [31:0] imm);
  inst_u w;
  w = '0;
  case (op)
    op_lui, op_auipc: begin
      w.u.opcode = op;
      w.u.rd     = rd;
      w.u.imm    = imm[31:12];
    end
    op_jal: begin
      w.j.opcode    = op;
      w.j.rd        = rd;
      w.j.imm_20    = imm[20];
      w.j.imm_19_12 = imm[19:12];
      w.j.imm_11    = imm[11];
      w.j.imm_10_1  = imm[10:1];
    end
    op_store: begin
      w.s.opcode = op;
      w.s.funct3 = f3;
      w.s.rs1    = rs1;
      w.s.rs2    = rs2;
      w.s.imm_hi = imm[11:5];
      w.s.imm_lo = imm[4:0];
    end
    op_system: w = ebreak_word;
    default: begin
      w.i.opcode = op;
      w.i.funct3 = f3;
      w.i.rd     = rd;
      w.i.rs1    = rs1;
      w.i.imm    = imm[11:0];
    end
  endcase
  rom[prog_len]      = w;
  prog_op[prog_len]  = op;
  prog_f3[prog_len]  = f3;
  prog_rd[prog_len]  = rd;
  prog_rs1[prog_len] = rs1;
  prog_rs2[prog_len] = rs2;
  prog_imm[prog_len] = imm;
  prog_len++;
endtask

task automatic save_reg(logic [4:0] rs);
  add_instr(op_store, f3_word, 5'd0, 5'd5, rs, out_off);
  out_off += 4;
endtask

task automatic build_program();
  prog_len = '0;
  out_off  = 'h80;
  // first word sits on the bus all through reset
  add_instr(op_store, f3_word, 5'd0, 5'd0, 5'd0, 32'h0000_007c); // clears word 31
  add_instr(op_lui, 3'd0, 5'd5, 5'd0, 5'd0, 32'h0000_1000); // x5 is the data base
  add_instr(op_lui, 3'd0, 5'd1, 5'd0, 5'd0, upper_imm());
  add_instr(op_auipc, 3'd0, 5'd2, 5'd0, 5'd0, upper_imm());
  add_instr(op_imm, f3_addi, 5'd3, 5'd1, 5'd0, small_imm());
  add_instr(op_imm, f3_addi, 5'd0, 5'd1, 5'd0, small_imm()); // lost in x0
  add_instr(op_imm, f3_addi, 5'd4, 5'd0, 5'd0, small_imm());
  save_reg(5'd1);
  save_reg(5'd2);
  save_reg(5'd3);
  save_reg(5'd0);
  save_reg(5'd4);
  // loads from preloaded words 0..4, each result saved
  for (int k = 0; k < 4; k++) begin
    add_instr(op_load, f3_byte, 5'd10, 5'd5, 5'd0, 32'(k));
    save_reg(5'd10);
    add_instr(op_load, f3_byte_u, 5'd10, 5'd5, 5'd0, 32'(4 + k));
    save_reg(5'd10);
  end
  for (int k = 0; k < 2; k++) begin
    add_instr(op_load, f3_half, 5'd10, 5'd5, 5'd0, 32'(8 + 2 * k));
    save_reg(5'd10);
    add_instr(op_load, f3_half_u, 5'd10, 5'd5, 5'd0, 32'(12 + 2 * k));
    save_reg(5'd10);
  end
  add_instr(op_load, f3_word, 5'd10, 5'd5, 5'd0, 32'd16);
  save_reg(5'd10);
  // partial stores into preloaded words 8..14
  add_instr(op_lui, 3'd0, 5'd11, 5'd0, 5'd0, upper_imm());
  add_instr(op_imm, f3_addi, 5'd11, 5'd11, 5'd0, small_imm());
  for (int k = 0; k < 4; k++) begin
    add_instr(op_store, f3_byte, 5'd0, 5'd5, 5'd11, 32'(32 + 5 * k));
  end
  add_instr(op_store, f3_half, 5'd0, 5'd5, 5'd11, 32'h30);
  add_instr(op_store, f3_half, 5'd0, 5'd5, 5'd11, 32'h36);
  add_instr(op_store, f3_word, 5'd0, 5'd5, 5'd11, 32'h38);
  add_instr(op_jal, 3'd0, 5'd6, 5'd0, 5'd0, 32'd8);
  add_instr(op_imm, f3_addi, 5'd6, 5'd0, 5'd0, 32'd1);  // jumped over
  save_reg(5'd6);
  add_instr(op_auipc, 3'd0, 5'd8, 5'd0, 5'd0, 32'd0);
  add_instr(op_jalr, 3'd0, 5'd9, 5'd8, 5'd0, 32'd13);   // odd target, lands at +12
  add_instr(op_imm, f3_addi, 5'd9, 5'd0, 5'd0, 32'd1);  // jumped over
  save_reg(5'd9);
  add_instr(op_system, 3'd0, 5'd0, 5'd0, 5'd0, 32'd0);
endtask

task automatic preload_ram();
  logic [31:0] w;
  for (int k = 0; k < mem_words; k++) begin
    w            = next_random();
    ram[6'(k)]   = w;
    m_ram[6'(k)] = w;
  end
endtask

function automatic logic ram_matches();
  logic same;
  same = 1'b1;
  for (int k = 0; k < mem_words; k++) begin
    if (ram[6'(k)] !== m_ram[6'(k)]) same = 1'b0;
  end
  return same;
endfunction

function automatic logic req_matches(dmem_req_t got, dmem_req_t want);
  logic same;
  same = (got.read == want.read) && (got.write == want.write) && (got.wmask == want.wmask);
  if (want.read || want.write) same = same && (got.addr == want.addr);
  if (want.write) same = same && (got.wdata == want.wdata);
  return same;
endfunction

// executes the record at m_pc and sets the predictions for this cycle
task automatic step_model();
  logic [5:0]  idx;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] addr;
  logic [31:0] lane;
  logic [31:0] result;
  logic [31:0] next_pc;
  logic        wr;
  idx        = m_pc[7:2];
  a          = m_regs[prog_rs1[idx]];
  b          = m_regs[prog_rs2[idx]];
  addr       = a + prog_imm[idx];
  lane       = m_ram[addr[7:2]] >> {addr[1:0], 3'b000};
  result     = '0;
  next_pc    = m_pc + 32'd4;
  wr         = 1'b0;
  exp_pc     = m_pc;
  exp_halted = m_halted;
  exp_req    = '0;
  if (!m_halted) begin
    case (prog_op[idx])
      op_lui: begin
        result = prog_imm[idx];
        wr     = 1'b1;
      end
      op_auipc: begin
        result = m_pc + prog_imm[idx];
        wr     = 1'b1;
      end
      op_imm: begin
        result = addr;
        wr     = 1'b1;
      end
      op_jal: begin
        result  = m_pc + 32'd4;
        next_pc = m_pc + prog_imm[idx];
        wr      = 1'b1;
      end
      op_jalr: begin
        result  = m_pc + 32'd4;
        next_pc = addr & ~32'd1;
        wr      = 1'b1;
      end
      op_load: begin
        exp_req.read = 1'b1;
        exp_req.addr = addr;
        wr           = 1'b1;
        case (prog_f3[idx])
          f3_byte:   result = {{24{lane[7]}}, lane[7:0]};
          f3_half:   result = {{16{lane[15]}}, lane[15:0]};
          f3_byte_u: result = {24'h00_0000, lane[7:0]};
          f3_half_u: result = {16'h0000, lane[15:0]};
          default:   result = lane;
        endcase
      end
      op_store: begin
        exp_req.write = 1'b1;
        exp_req.addr  = addr;
        case (prog_f3[idx])
          f3_byte: begin
            exp_req.wdata = {4{b[7:0]}};
            exp_req.wmask = 4'b0001 << addr[1:0];
          end
          f3_half: begin
            exp_req.wdata = {2{b[15:0]}};
            exp_req.wmask = 4'b0011 << addr[1:0];
          end
          default: begin
            exp_req.wdata = b;
            exp_req.wmask = 4'b1111;
          end
        endcase
        m_ram[addr[7:2]] = merge_lanes(m_ram[addr[7:2]], exp_req.wdata, exp_req.wmask);
      end
      default: begin
        m_halted = 1'b1; // ebreak, pc stays put
        next_pc  = m_pc;
      end
    endcase
    if (wr && (prog_rd[idx] != 5'd0)) m_regs[prog_rd[idx]] = result;
    m_pc = next_pc;
  end
endtask

//--- tb_core.sv
`timescale 1ns/100ps

module tb_core
  import rv_isa_pkg::*;
  import core_pkg::*;
();

  // ~55 instructions plus reset and the halt tail, with wide margin
  localparam int unsigned timeout_cycles = 200;
  localparam int unsigned mem_words      = 64;

  logic      clk;
  logic      reset;
  logic [31:0] inst;
  logic [31:0] pc;
  dmem_req_t dmem_req;
  logic [31:0] dmem_rdata;
  logic      halted;

  logic [31:0] rom [mem_words];
  logic [31:0] ram [mem_words];   // only addr[7:2] decoded, data base is 0x1000

  // one record per ROM word, read by the shadow model
  opcode_t     prog_op  [mem_words];
  logic [2:0]  prog_f3  [mem_words];
  logic [4:0]  prog_rd  [mem_words];
  logic [4:0]  prog_rs1 [mem_words];
  logic [4:0]  prog_rs2 [mem_words];
  logic [31:0] prog_imm [mem_words];
  logic [5:0]  prog_len;

  logic [31:0] m_pc;
  logic        m_halted;
  logic [31:0] m_regs [32];
  logic [31:0] m_ram [mem_words];

  // predictions for the cycle in flight
  logic [31:0] exp_pc;
  logic        exp_halted;
  dmem_req_t   exp_req;
  logic        ram_ok;

  int unsigned cycles;
  logic [31:0] rng_state;

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] data,
                                              logic [3:0] mask);
    logic [31:0] word;
    word = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) word[8*b +: 8] = data[8*b +: 8];
    end
    return word;
  endfunction

  task automatic stop_run(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  `include "tb_program.svh"

  core_top dut0 (
    .clk        (clk),
    .reset      (reset),
    .inst       (inst),
    .pc         (pc),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halted     (halted)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    #1 inst = rom[pc[7:2]];
  end

  always @(posedge clk) begin
    if (dmem_req.write) begin
      ram[dmem_req.addr[7:2]] = merge_lanes(ram[dmem_req.addr[7:2]], dmem_req.wdata,
                                            dmem_req.wmask);
    end
  end

  always @(posedge clk) begin
    #2 dmem_rdata = ram[dmem_req.addr[7:2]]; // request has settled by now
  end

  // shadow step after both memories have answered
  always @(posedge clk) begin
    #3;
    if (!reset) begin
      ram_ok = ram_matches();
      step_model();
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      stop_run($sformatf("timeout: core did not halt within %0d cycles", cycles));
    end
  end

  // sampled mid-cycle where every port is stable
  assert property (@(negedge clk) disable iff (reset) pc == exp_pc)
    else stop_run($sformatf("[ERROR] %0t: pc %h, expected %h", $time, pc, exp_pc));

  assert property (@(negedge clk) disable iff (reset) halted == exp_halted)
    else stop_run($sformatf("[ERROR] %0t: halted %b, expected %b", $time, halted, exp_halted));

  assert property (@(negedge clk) disable iff (reset) req_matches(dmem_req, exp_req))
    else stop_run($sformatf("[ERROR] %0t: request %h, expected %h", $time, dmem_req, exp_req));

  assert property (@(negedge clk) disable iff (reset) ram_ok)
    else stop_run($sformatf("[ERROR] %0t: data RAM differs from the model", $time));

  assert property (@(negedge clk) reset |-> !dmem_req.read && !dmem_req.write)
    else stop_run($sformatf("[ERROR] %0t: memory request while in reset", $time));

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    inst       = '0;
    dmem_rdata = '0;
    rng_state  = 32'd87;
    cycles     = 0;
    ram_ok     = 1'b1;
    exp_pc     = reset_vector;
    exp_halted = 1'b0;
    exp_req    = '0;
    m_pc       = reset_vector;
    m_halted   = 1'b0;
    for (int r = 0; r < 32; r++) m_regs[5'(r)] = '0;
    build_program();
    preload_ram();
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    wait (halted === 1'b1);
    repeat (5) @(negedge clk); // halt must hold
    if (ram_ok && m_halted && halted && pc == exp_pc) begin
      $display(">>> PASS");
      $finish;
    end else begin
      stop_run("core state after the halt differs from the model");
    end
  end

endmodule

//--- sim.f
+incdir+.
rv_isa_pkg.sv
core_pkg.sv
regfile.sv
decoder.sv
lsu.sv
core_top.sv
tb_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
RTL_TOP   ?= core_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
RTL_SRCS  ?= rv_isa_pkg.sv core_pkg.sv regfile.sv decoder.sv lsu.sv core_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
